// File: hw/aluStage.sv
`timescale 1ns/1ps

module aluStage (
    input  logic                            clock,
    input  logic                            reset,
    input  srcDatapathPkg::controlStrobes_t ctrl,
    input  srcDatapathPkg::word_t           bus,
    output srcDatapathPkg::word_t           zValue
);
    import srcDatapathPkg::*;

    word_t yValue;
    word_t aluResult;

    // Y is the A operand, the bus is always B
    always_comb
    begin
        case (ctrl.aluOp)
            aluAdd:   aluResult = yValue + bus;
            aluSub:   aluResult = yValue - bus;
            aluAnd:   aluResult = yValue & bus;
            aluOr:    aluResult = yValue | bus;
            aluPassB: aluResult = bus;
            default:  aluResult = '0;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            yValue <= '0;
            zValue <= '0;
        end
        else
        begin
            if (ctrl.yIn)
                yValue <= bus;
            if (ctrl.zIn)
                zValue <= aluResult; // low 32 bits only
        end
    end

    aluOpLegal: assert property (
        @(posedge clock) disable iff (reset)
        ctrl.zIn |-> ctrl.aluOp inside {aluAdd, aluSub, aluAnd, aluOr, aluPassB}
    ) else $error("aluStage: zIn with unknown aluOp %0d", ctrl.aluOp);

endmodule

// File: hw/busMux.sv
`timescale 1ns/1ps

module busMux (
    input  srcDatapathPkg::controlStrobes_t ctrl,
    input  srcDatapathPkg::word_t           regData,
    input  srcDatapathPkg::word_t           constExt,
    input  srcDatapathPkg::word_t           zValue,
    input  srcDatapathPkg::word_t           dataIn,
    output srcDatapathPkg::word_t           bus
);
    import srcDatapathPkg::*;

    busSrc_t busSrc;
    logic    regOut;

    assign regOut = ctrl.rOut | ctrl.baOut; // both read the register file

    always_comb
    begin
        if (regOut)
            busSrc = srcReg;
        else if (ctrl.cOut)
            busSrc = srcConst;
        else if (ctrl.zOut)
            busSrc = srcZ;
        else if (ctrl.dataOut)
            busSrc = srcData;
        else
            busSrc = srcNone;
    end

    always_comb
    begin
        case (busSrc)
            srcReg:   bus = regData;
            srcConst: bus = constExt;
            srcZ:     bus = zValue;
            srcData:  bus = dataIn;
            default:  bus = '0; // idle bus reads zero
        endcase
    end

    always_comb
    begin
        assert final ($onehot0({regOut, ctrl.cOut, ctrl.zOut, ctrl.dataOut}))
        else $error("busMux: two drivers on the bus");
    end

endmodule

// File: hw/instructionRegister.sv
`timescale 1ns/1ps

module instructionRegister (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  irIn,
    input  srcDatapathPkg::word_t bus,
    output srcIsaPkg::irFields_t  ir
);
    import srcIsaPkg::*;
    import srcDatapathPkg::*;

    word_t irWord;

    always_ff @(posedge clock)
    begin
        if (reset)
            irWord <= '0;
        else if (irIn)
            irWord <= bus;
    end

    always_comb
    begin
        ir.opcode = opcode_t'(irWord[instrWidth-1 -: opcodeWidth]);
        ir.ra = irWord[raLsb +: regAddrWidth];
        ir.rb = irWord[rbLsb +: regAddrWidth];
        ir.tail.constant = irWord[constWidth-1:0]; // rc comes along with it
    end

endmodule

// File: hw/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                     clock,
    input  logic                     reset,
    input  srcDatapathPkg::regMask_t regWriteMask,
    input  srcDatapathPkg::regMask_t regReadMask,
    input  logic                     baOut,
    input  srcDatapathPkg::word_t    bus,
    output srcDatapathPkg::word_t    regData
);
    import srcIsaPkg::*;
    import srcDatapathPkg::*;

    word_t regs [numRegs];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < numRegs; i++)
                regs[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < numRegs; i++)
            begin
                if (regWriteMask[i])
                    regs[i] <= bus;
            end
        end
    end

    // and-or read that relies on a one-hot mask
    always_comb
    begin
        regData = '0;
        for (int i = 0; i < numRegs; i++)
        begin
            if (regReadMask[i] && !(i == 0 && baOut)) // R0 is zero as a base
                regData = regData | regs[i];
        end
    end

    writeMaskOneHot: assert property (
        @(posedge clock) disable iff (reset) $onehot0(regWriteMask)
    ) else $error("registerFile: write mask 0x%h not one-hot", regWriteMask);

    readMaskOneHot: assert property (
        @(posedge clock) disable iff (reset) $onehot0(regReadMask)
    ) else $error("registerFile: read mask 0x%h not one-hot", regReadMask);

endmodule

// File: hw/selectEncode.sv
`timescale 1ns/1ps

module selectEncode (
    input  srcIsaPkg::irFields_t            ir,
    input  srcDatapathPkg::controlStrobes_t ctrl,
    output srcDatapathPkg::regMask_t        regWriteMask,
    output srcDatapathPkg::regMask_t        regReadMask,
    output srcDatapathPkg::word_t           constExt
);
    import srcIsaPkg::*;
    import srcDatapathPkg::*;

    regAddr_t regAddr;
    regMask_t decoded;
    logic     readEnable;
    logic     constSign;

    // each field is masked by its own strobe, then merged
    always_comb
    begin
        regAddr = (ir.ra & {regAddrWidth{ctrl.gra}})
                | (ir.rb & {regAddrWidth{ctrl.grb}})
                | (ir.tail.rcView.rc & {regAddrWidth{ctrl.grc}});
    end

    always_comb
    begin
        decoded = '0;
        decoded[regAddr] = 1'b1; // 4-to-16
    end

    assign readEnable = ctrl.rOut | ctrl.baOut;

    assign regWriteMask = ctrl.rIn ? decoded : '0;
    assign regReadMask = readEnable ? decoded : '0;

    assign constSign = ir.tail.constant[constWidth-1];
    assign constExt = {{(wordWidth - constWidth){constSign}}, ir.tail.constant};

    // OR of two fields would name a register nobody asked for
    always_comb
    begin
        assert final ($onehot0({ctrl.gra, ctrl.grb, ctrl.grc}))
        else $error("selectEncode: more than one of gra, grb, grc set");
    end

endmodule

// File: hw/srcDatapath.sv
`timescale 1ns/1ps

module srcDatapath (
    input  logic                            clock,
    input  logic                            reset,
    input  srcDatapathPkg::controlStrobes_t ctrl,
    input  srcDatapathPkg::word_t           dataIn,
    output srcDatapathPkg::word_t           busValue,
    output srcIsaPkg::irFields_t            ir
);
    import srcDatapathPkg::*;

    regMask_t regWriteMask;
    regMask_t regReadMask;
    word_t    constExt;
    word_t    regData;
    word_t    zValue;

    instructionRegister instructionRegister_i (
        .clock (clock),
        .reset (reset),
        .irIn  (ctrl.irIn),
        .bus   (busValue),
        .ir    (ir)
    );

    selectEncode selectEncode_i (
        .ir           (ir),
        .ctrl         (ctrl),
        .regWriteMask (regWriteMask),
        .regReadMask  (regReadMask),
        .constExt     (constExt)
    );

    registerFile registerFile_i (
        .clock        (clock),
        .reset        (reset),
        .regWriteMask (regWriteMask),
        .regReadMask  (regReadMask),
        .baOut        (ctrl.baOut),
        .bus          (busValue),
        .regData      (regData)
    );

    // single shared bus that every destination samples
    busMux busMux_i (
        .ctrl     (ctrl),
        .regData  (regData),
        .constExt (constExt),
        .zValue   (zValue),
        .dataIn   (dataIn),
        .bus      (busValue)
    );

    aluStage aluStage_i (
        .clock  (clock),
        .reset  (reset),
        .ctrl   (ctrl),
        .bus    (busValue),
        .zValue (zValue)
    );

endmodule

// File: hw/srcDatapathPkg.sv
package srcDatapathPkg;

    localparam int wordWidth = 32;

    typedef logic [wordWidth-1:0] word_t;

    typedef logic [srcIsaPkg::numRegs-1:0] regMask_t; // one bit per register

    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluAnd   = 3'd2,
        aluOr    = 3'd3,
        aluPassB = 3'd4
    } aluOp_t;

    typedef struct packed {
        logic gra;
        logic grb;
        logic grc;
        logic rIn;
        logic rOut;
        logic baOut;      // base address out where R0 reads as zero
        logic cOut;
        logic zOut;
        logic dataOut;    // stands in for the MDR
        logic irIn;
        logic yIn;
        logic zIn;
        aluOp_t aluOp;
    } controlStrobes_t;

    typedef enum logic [2:0] {
        srcNone,
        srcReg,
        srcConst,
        srcZ,
        srcData
    } busSrc_t;

endpackage

// File: hw/srcIsaPkg.sv
package srcIsaPkg;

    localparam int instrWidth = 32;
    localparam int raLsb = 23;
    localparam int rbLsb = 19;
    localparam int rcLsb = 15;
    localparam int regAddrWidth = 4;
    localparam int numRegs = 16;
    localparam int constWidth = 19;
    localparam int opcodeWidth = instrWidth - raLsb - regAddrWidth; // bits 31:27

    typedef enum logic [opcodeWidth-1:0] {
        opLd   = 5'd0,
        opLdi  = 5'd1,
        opSt   = 5'd2,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opAddi = 5'd12,
        opAndi = 5'd13,
        opOri  = 5'd14
    } opcode_t;

    typedef logic [regAddrWidth-1:0] regAddr_t;

    typedef struct packed {
        regAddr_t rc;
        logic [rcLsb-1:0] low;
    } rcField_t;

    // rc sits in the top four bits of the constant field
    typedef union packed {
        rcField_t rcView;
        logic [constWidth-1:0] constant;
    } irTail_t;

    typedef struct packed {
        opcode_t opcode;
        regAddr_t ra;
        regAddr_t rb;
        irTail_t tail;
    } irFields_t;

endpackage

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module srcDatapathTb \
    -Mdir obj_dir -o simv -f vlog.f \
    && ./obj_dir/simv | tee sim.log \
    || { echo "build or simulation step failed"; exit 1; }

grep -qF "** PASS **" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verification/srcDatapathTb.sv
`timescale 1ns/1ps

module srcDatapathTb;
    import srcIsaPkg::*;
    import srcDatapathPkg::*;

    localparam int randomRounds = 32;
    // fill pass, random rounds, final read-back pass
    localparam int randomSteps = 2 * numRegs + 3 * randomRounds + 2 * numRegs;

    logic            clock;
    logic            reset;
    controlStrobes_t ctrl;
    word_t           dataIn;
    word_t           busValue;
    irFields_t       ir;

    controlStrobes_t fileCtrl [$];
    word_t           fileData [$];
    logic            fileCheck [$];
    word_t           fileExpect [$];
    int              fileLine [$];

    word_t       model [numRegs]; // expected register contents
    word_t       irExpected;
    logic [31:0] lfsrState;
    int          cycleCount;
    int          cycleLimit;
    int          checkCount;
    int          valueErrors;
    int          otherErrors;
    string       stepTag;

    srcDatapath srcDatapath_i (
        .clock    (clock),
        .reset    (reset),
        .ctrl     (ctrl),
        .dataIn   (dataIn),
        .busValue (busValue),
        .ir       (ir)
    );

    always #5 clock = ~clock;

    always @(posedge clock)
    begin
        cycleCount = cycleCount + 1;
        if (cycleLimit != 0 && cycleCount > cycleLimit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0]; // x^32+x^22+x^2+x+1
        return {state[30:0], feedback};
    endfunction

    task automatic drawBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    // strobe groups {gra grb grc} {rIn rOut baOut} {cOut zOut dataOut} {irIn yIn zIn} aluOp
    function automatic controlStrobes_t packStrobes(input logic [2:0] sel, input logic [2:0] rio,
                                                    input logic [2:0] outs, input logic [2:0] lds,
                                                    input logic [2:0] op);
        return controlStrobes_t'({sel, rio, outs, lds, op});
    endfunction

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        checkCount++;
        if (actual !== expected)
        begin
            valueErrors++;
            $display("[FAIL] %s expected 0x%08h actual 0x%08h at %s", name, expected, actual,
                     stepTag);
        end
    endtask

    task automatic runStep(input controlStrobes_t c, input word_t d, input logic doCheck,
                           input word_t expected);
        @(posedge clock);
        #1;
        checkValue("ir", irExpected, word_t'(ir)); // loaded at the edge just passed
        ctrl = c;
        dataIn = d;
        @(negedge clock); // bus has settled by mid-cycle
        if (doCheck)
            checkValue("busValue", expected, busValue);
        if (c.irIn)
            irExpected = expected;
    endtask

    task automatic loadIr(input word_t word);
        runStep(packStrobes(3'b000, 3'b000, 3'b001, 3'b100, 3'b000), word, 1'b1, word);
    endtask

    task automatic readTests();
        int          fd;
        int          count;
        int          lineNo;
        int          got;
        string       line;
        logic [2:0]  sel;
        logic [2:0]  rio;
        logic [2:0]  outs;
        logic [2:0]  lds;
        logic [2:0]  op;
        logic [3:0]  chk;
        logic [31:0] data;
        logic [31:0] expected;
        fd = $fopen("verification/srcDatapathTests.txt", "r");
        if (fd == 0)
        begin
            otherErrors++;
            $display("could not open verification/srcDatapathTests.txt");
            return;
        end
        lineNo = 0;
        while (!$feof(fd))
        begin
            line = "";
            got = $fgets(line, fd);
            lineNo++;
            if (got == 0 || line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            count = $sscanf(line, "%h %h %h %h %h %h %h %h", sel, rio, outs, lds, op, data,
                            chk, expected);
            if (count != 8)
            begin
                otherErrors++;
                $display("line %0d of the test file could not be parsed", lineNo);
            end
            else
            begin
                fileCtrl.push_back(packStrobes(sel, rio, outs, lds, op));
                fileData.push_back(data);
                fileCheck.push_back(chk != 4'd0);
                fileExpect.push_back(expected);
                fileLine.push_back(lineNo);
            end
        end
        $fclose(fd);
    endtask

    task automatic randomPhase();
        logic [31:0] data;
        logic [31:0] wrReg;
        logic [31:0] rdReg;
        for (int k = 0; k < numRegs; k++)
        begin
            drawBits(32, data);
            stepTag = $sformatf("fill of r%0d", k);
            loadIr(word_t'(k) << raLsb);
            runStep(packStrobes(3'b100, 3'b100, 3'b001, 3'b000, 3'b000), data, 1'b1, data);
            model[k] = data;
        end
        for (int n = 0; n < randomRounds; n++)
        begin
            drawBits(regAddrWidth, wrReg);
            drawBits(regAddrWidth, rdReg);
            drawBits(32, data);
            stepTag = $sformatf("random round %0d", n);
            loadIr((wrReg << raLsb) | (rdReg << rbLsb)); // write through ra, read through rb
            runStep(packStrobes(3'b100, 3'b100, 3'b001, 3'b000, 3'b000), data, 1'b1, data);
            model[wrReg[3:0]] = data;
            runStep(packStrobes(3'b010, 3'b010, 3'b000, 3'b000, 3'b000), '0, 1'b1,
                    model[rdReg[3:0]]);
        end
        for (int k = 0; k < numRegs; k++)
        begin
            stepTag = $sformatf("read-back of r%0d", k);
            loadIr(word_t'(k) << rcLsb);
            runStep(packStrobes(3'b001, 3'b010, 3'b000, 3'b000, 3'b000), '0, 1'b1, model[k]);
        end
    endtask

    initial
    begin
        clock = 1'b0;
        reset = 1'b1;
        ctrl = '0;
        dataIn = '0;
        irExpected = '0;
        lfsrState = 32'h3cc81114;
        cycleCount = 0;
        cycleLimit = 0;
        checkCount = 0;
        valueErrors = 0;
        otherErrors = 0;
        stepTag = "reset";
        readTests();
        cycleLimit = 2 * fileCtrl.size() + randomSteps + 100;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int i = 0; i < fileCtrl.size(); i++)
        begin
            stepTag = $sformatf("test file line %0d", fileLine[i]);
            runStep(fileCtrl[i], fileData[i], fileCheck[i], fileExpect[i]);
        end
        randomPhase();
        @(posedge clock);
        #1;
        ctrl = '0;
        $display("checks %0d, value errors %0d, other errors %0d", checkCount, valueErrors,
                 otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: verification/srcDatapathTests.txt
# sel={gra,grb,grc} rio={rIn,rOut,baOut} out={cOut,zOut,dataOut} ld={irIn,yIn,zIn} op=aluOp
# sel rio out ld op dataIn check expectedBus, all hex, one control step per line
0 0 0 0 0 00000000 1 00000000   # idle bus
0 0 0 0 0 5a5a5a5a 1 00000000   # dataIn without dataOut
0 0 1 4 0 1ab38000 1 1ab38000   # IR = add r5, r6, r7
4 2 0 0 0 00000000 1 00000000
2 2 0 0 0 00000000 1 00000000
1 2 0 0 0 00000000 1 00000000
4 4 1 0 0 11112222 1 11112222   # r5 through gra
2 4 1 0 0 0000000a 1 0000000a   # r6 through grb
1 4 1 0 0 00000003 1 00000003   # r7 through grc
4 2 0 0 0 00000000 1 11112222
2 2 0 0 0 00000000 1 0000000a
1 2 0 0 0 00000000 1 00000003
2 2 0 2 0 00000000 1 0000000a   # add, Y = r6
1 2 0 1 0 00000000 1 00000003
4 4 2 0 0 00000000 1 0000000d   # r5 = Z
4 2 0 0 0 00000000 1 0000000d
2 2 0 2 0 00000000 1 0000000a   # sub
1 2 0 1 1 00000000 1 00000003
4 4 2 0 0 00000000 1 00000007
2 2 0 2 0 00000000 1 0000000a   # and
1 2 0 1 2 00000000 1 00000003
4 4 2 0 0 00000000 1 00000002
2 2 0 2 0 00000000 1 0000000a   # or
1 2 0 1 3 00000000 1 00000003
4 4 2 0 0 00000000 1 0000000b
1 2 0 2 0 00000000 1 00000003   # sub r7 - r6 wraps
2 2 0 1 1 00000000 1 0000000a
4 4 2 0 0 00000000 1 fffffff9
4 2 0 0 0 00000000 1 fffffff9
2 2 0 0 0 00000000 1 0000000a   # r6 kept
1 2 0 0 0 00000000 1 00000003
0 0 1 4 0 6407fff0 1 6407fff0   # IR = addi r8, r0, -16, rc = 15
2 4 1 0 0 cafe0001 1 cafe0001   # r0 written
2 2 0 0 0 00000000 1 cafe0001
2 1 0 0 0 00000000 1 00000000   # baOut on r0
1 4 1 0 0 0000beef 1 0000beef   # r15
1 2 0 0 0 00000000 1 0000beef
1 1 0 0 0 00000000 1 0000beef
0 0 4 0 0 00000000 1 fffffff0   # bit 18 set
2 1 0 2 0 00000000 1 00000000   # addi, Y = 0 from baOut
0 0 4 1 0 00000000 1 fffffff0
4 4 2 0 0 00000000 1 fffffff0
4 2 0 0 0 00000000 1 fffffff0
0 0 1 4 0 64f92345 1 64f92345   # IR = addi r9, r15, 0x12345
0 0 4 0 0 00000000 1 00012345   # bit 18 clear
2 1 0 2 0 00000000 1 0000beef
0 0 4 1 0 00000000 1 00012345
4 4 2 0 0 00000000 1 0001e234
4 2 0 0 0 00000000 1 0001e234
2 2 0 0 0 00000000 1 0000beef
0 0 0 0 0 00000000 1 00000000

// File: vlog.f
hw/srcIsaPkg.sv
hw/srcDatapathPkg.sv
hw/instructionRegister.sv
hw/selectEncode.sv
hw/registerFile.sv
hw/busMux.sv
hw/aluStage.sv
hw/srcDatapath.sv
verification/srcDatapathTb.sv
